// ==== sim.f ====
+incdir+.
axi_pkg.sv
fetch_pkg.sv
icache.sv
ifu.sv
fetch_top.sv
fetch_chk.sv
tb_fetch.sv

// ==== tb_fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defines.svh"

module tb_fetch;
    localparam int          CYCLE_LIMIT = 4000;
    localparam int          WORDS       = `FETCH_LINE_BYTES / 4;
    localparam logic [31:0] MODEL_XOR   = 32'h5A5A_0000;
    localparam logic [31:0] ERR_BASE    = 32'h2000_0000;
    localparam logic [31:0] ERR_END     = 32'h2000_FFFF;

    logic                     clk;
    logic                     rst;
    fetch_pkg::redirect_t     redirect;
    logic                     idu_ready;
    logic                     arready;
    logic                     rvalid;
    axi_pkg::r_beat_t         r;
    logic                     ifu_valid;
    fetch_pkg::fetch_bundle_t bundle;
    logic                     access_fault;
    logic                     arvalid;
    axi_pkg::ar_req_t         ar;
    logic                     rready;

    logic [15:0]      bus_lfsr = 16'd40;
    logic [15:0]      gap_lfsr = 16'd40;
    logic             model_valid [`FETCH_LINES];
    logic [31:0]      model_tag   [`FETCH_LINES];
    axi_pkg::ar_req_t ar_log [$];
    logic [31:0]      exp_pc;
    logic             started;
    string            cur_test;
    int               ar_total     = 0;
    int               exp_ar_total = 0;
    int               cycles       = 0;
    int               errors       = 0;
    int               checks       = 0;
    int               tests        = 0;
    int               test_errors  = 0;

    fetch_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .redirect     (redirect),
        .idu_ready    (idu_ready),
        .arready      (arready),
        .rvalid       (rvalid),
        .r            (r),
        .ifu_valid    (ifu_valid),
        .bundle       (bundle),
        .access_fault (access_fault),
        .arvalid      (arvalid),
        .ar           (ar),
        .rready       (rready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(inout logic [15:0] s, input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            s = lfsr_next(s);
            v = (v << 1) | int'(s[0]);
        end
    endtask

    function automatic logic in_err_region(input logic [31:0] a);
        return (a >= ERR_BASE) && (a <= ERR_END);
    endfunction

    function automatic logic in_sdram(input logic [31:0] a);
        return (a >= `SDRAM_BASE) && (a <= `SDRAM_END);
    endfunction

    task automatic send_beat(input axi_pkg::ar_req_t req, input int beat);
        logic [31:0] addr;
        addr = (req.burst == axi_pkg::INCR) ? req.addr + 32'(beat * 4) : req.addr;
        r.data = addr ^ MODEL_XOR;
        r.resp = in_err_region(addr) ? axi_pkg::SLVERR : axi_pkg::OKAY;
        r.last = (beat == int'(req.len));
        r.id   = '0;
        rvalid = 1'b1;
        while (!rready) @(negedge clk); // beat held until the master takes it.
        @(negedge clk);
        rvalid = 1'b0;
    endtask

    initial begin : axi_slave
        axi_pkg::ar_req_t req;
        int               delay;
        forever begin
            @(negedge clk);
            if (!rst && arvalid) begin
                req = ar;
                take_bits(bus_lfsr, 2, delay);
                repeat (delay) @(negedge clk);
                arready = 1'b1;
                @(negedge clk);
                arready = 1'b0;
                ar_log.push_back(req);
                ar_total++;
                for (int beat = 0; beat <= int'(req.len); beat++) begin
                    take_bits(bus_lfsr, 2, delay);
                    repeat (delay) @(negedge clk);
                    send_beat(req, beat);
                end
            end
        end
    end

    task automatic check_bundle(input string what, input fetch_pkg::fetch_bundle_t exp,
                                input fetch_pkg::fetch_bundle_t act);
        checks++;
        if (exp !== act) begin
            test_errors++;
            $display("Error: %s: %s expected pc %h inst %h, actual pc %h inst %h",
                     cur_test, what, exp.pc, exp.inst, act.pc, act.inst);
        end
    endtask

    task automatic check_ar(input string what, input axi_pkg::ar_req_t exp,
                            input axi_pkg::ar_req_t act);
        checks++;
        if (exp !== act) begin
            test_errors++;
            $write("Error: %s: %s expected addr %h len %0d size %0d burst %0d, ",
                   cur_test, what, exp.addr, exp.len, exp.size, exp.burst);
            $display("actual addr %h len %0d size %0d burst %0d",
                     act.addr, act.len, act.size, act.burst);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            test_errors++;
            $display("Error: %s: %s expected %b actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        checks++;
        if (exp != act) begin
            test_errors++;
            $display("Error: %s: %s expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    // direct-mapped tag model; faulting lines are never filled.
    task automatic predict(input logic [31:0] pc, output fetch_pkg::fetch_bundle_t exp_b,
                           output logic exp_fault, output int exp_ars);
        int          idx;
        logic [31:0] tag;
        logic        miss;
        idx       = int'((pc / `FETCH_LINE_BYTES) % `FETCH_LINES);
        tag       = pc / (`FETCH_LINE_BYTES * `FETCH_LINES);
        miss      = !(model_valid[idx] && model_tag[idx] == tag);
        exp_fault = in_err_region(pc);
        exp_ars   = !miss ? 0 : (in_sdram(pc) || exp_fault) ? 1 : WORDS;
        if (miss && !exp_fault) begin
            model_valid[idx] = 1'b1;
            model_tag[idx]   = tag;
        end
        exp_b.pc   = pc;
        exp_b.inst = exp_fault ? 32'd0 : pc ^ MODEL_XOR;
    endtask

    // entered in the ifu_valid cycle of the previous fetch, so a redirect
    // given here is sampled at the edge that closes that cycle.
    task automatic fetch(input logic redir_v, input logic [31:0] target, input int gap,
                         output int lat);
        fetch_pkg::fetch_bundle_t exp_b;
        logic                     exp_fault;
        int                       exp_ars;
        if (started) begin
            redirect.valid  = redir_v;
            redirect.target = target;
            @(negedge clk);
            redirect = '0;
            if (redir_v) begin
                exp_pc = target;
            end
        end
        predict(exp_pc, exp_b, exp_fault, exp_ars);
        ar_log.delete();
        repeat (gap) @(negedge clk);
        idu_ready = 1'b1;
        @(negedge clk);
        idu_ready = 1'b0;
        lat = 0;
        while (!ifu_valid) begin
            @(negedge clk);
            lat++;
        end
        started = 1'b1;
        check_bundle("bundle", exp_b, bundle);
        check_flag("access_fault", exp_fault, access_fault);
        check_count("AR count", exp_ars, ar_log.size());
        exp_ar_total += exp_ars;
        exp_pc = exp_pc + 32'd4;
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
        tests++;
    endtask

    task automatic end_test();
        errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: FAILED with %0d errors", cur_test, test_errors);
        end
    endtask

    task automatic reset_and_first_fetch();
        axi_pkg::ar_req_t exp_ar;
        int               lat;
        begin_test("reset and first fetch");
        check_flag("ifu_valid after reset", 1'b0, ifu_valid);
        check_flag("arvalid after reset", 1'b0, arvalid);
        check_flag("rready after reset", 1'b0, rready);
        fetch(1'b0, '0, 0, lat);
        for (int i = 0; i < WORDS; i++) begin
            exp_ar.addr  = `FETCH_RESET_PC + 32'(i * 4);
            exp_ar.len   = 8'd0;
            exp_ar.size  = 3'd2;
            exp_ar.burst = axi_pkg::FIXED;
            if (i < ar_log.size()) begin
                check_ar($sformatf("AR %0d", i), exp_ar, ar_log[i]);
            end
        end
        end_test();
    endtask

    task automatic sequential_hits();
        int lat;
        begin_test("sequential hits");
        for (int i = 0; i < 3; i++) begin
            fetch(1'b0, '0, 0, lat);
            check_count("hit latency in edges", 2, lat);
        end
        end_test();
    endtask

    task automatic redirect_to_sdram();
        axi_pkg::ar_req_t exp_ar;
        int               lat;
        begin_test("redirect into SDRAM");
        fetch(1'b1, 32'hA000_0044, 0, lat);
        exp_ar.addr  = 32'hA000_0040;
        exp_ar.len   = 8'(WORDS - 1);
        exp_ar.size  = 3'd2;
        exp_ar.burst = axi_pkg::INCR;
        if (ar_log.size() > 0) begin
            check_ar("burst AR", exp_ar, ar_log[0]);
        end
        fetch(1'b0, '0, 0, lat);
        check_count("hit latency in edges", 2, lat);
        end_test();
    endtask

    task automatic access_fault_refetch();
        int lat;
        begin_test("access fault");
        fetch(1'b1, 32'h2000_0010, 0, lat);
        fetch(1'b1, 32'h2000_0010, 0, lat); // same line again must miss.
        check_flag("refetch faults", 1'b1, access_fault);
        end_test();
    endtask

    task automatic conflict_eviction();
        int lat;
        begin_test("conflict eviction");
        fetch(1'b1, `FETCH_RESET_PC + `FETCH_LINE_BYTES * `FETCH_LINES, 0, lat);
        fetch(1'b1, `FETCH_RESET_PC, 0, lat);
        check_count("refill ARs after eviction", WORDS, ar_log.size());
        end_test();
    endtask

    function automatic logic [31:0] pick_base(input int sel);
        case (sel)
            0:       return `FETCH_RESET_PC;
            1:       return 32'h3000_0100;
            2:       return `SDRAM_BASE;
            default: return ERR_BASE;
        endcase
    endfunction

    task automatic random_backpressure();
        int          sel;
        int          base_sel;
        int          off;
        int          gap;
        int          lat;
        int          ars_before;
        int          exp_before;
        logic [31:0] target;
        begin_test("random back-pressure");
        ars_before = ar_total;
        exp_before = exp_ar_total;
        for (int i = 0; i < 20; i++) begin
            take_bits(gap_lfsr, 2, sel);
            take_bits(gap_lfsr, 2, base_sel);
            take_bits(gap_lfsr, 4, off);
            take_bits(gap_lfsr, 2, gap);
            target = pick_base(base_sel) + 32'(off * 4);
            fetch(sel == 0, target, gap, lat);
        end
        check_count("total ARs", exp_ar_total - exp_before, ar_total - ars_before);
        end_test();
    endtask

    initial begin
        redirect  = '0;
        idu_ready = 1'b0;
        arready   = 1'b0;
        rvalid    = 1'b0;
        r         = '0;
        rst       = 1'b1;
        exp_pc    = `FETCH_RESET_PC;
        started   = 1'b0;
        for (int i = 0; i < `FETCH_LINES; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_and_first_fetch();
        sequential_hits();
        redirect_to_sdram();
        access_fault_refetch();
        conflict_eviction();
        random_backpressure();
        errors += i_dut.i_chk.fails; // bound assertion failures.
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fetch_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_chk (
    input wire              clk,
    input wire              rst,
    input wire              arvalid,
    input wire              arready,
    input wire axi_pkg::ar_req_t ar,
    input wire              rvalid,
    input wire              rready,
    input wire axi_pkg::r_beat_t r,
    input wire              ifu_valid,
    input wire              access_fault
);
    int unsigned fails = 0;

    // address channel must hold while the slave stalls.
    property ar_held;
        @(posedge clk) disable iff (rst) arvalid && !arready |=> arvalid && $stable(ar);
    endproperty

    property valid_one_cycle;
        @(posedge clk) disable iff (rst) ifu_valid |=> !ifu_valid;
    endproperty

    // a fault is delivered with ifu_valid, three edges after the error beat.
    property fault_with_valid;
        @(posedge clk) disable iff (rst)
            access_fault |-> ifu_valid &&
                $past(rvalid && rready && (r.resp != axi_pkg::OKAY), 3);
    endproperty

    ar_held_a: assert property (ar_held) else begin
        fails++;
        $error("arvalid or ar changed before arready");
    end

    valid_one_cycle_a: assert property (valid_one_cycle) else begin
        fails++;
        $error("ifu_valid high for more than one cycle");
    end

    fault_with_valid_a: assert property (fault_with_valid) else begin
        fails++;
        $error("access_fault without ifu_valid or without an error beat before it");
    end

endmodule

bind fetch_top fetch_chk i_chk (
    .clk          (clk),
    .rst          (rst),
    .arvalid      (arvalid),
    .arready      (arready),
    .ar           (ar),
    .rvalid       (rvalid),
    .rready       (rready),
    .r            (r),
    .ifu_valid    (ifu_valid),
    .access_fault (access_fault)
);

`default_nettype wire

// ==== fetch_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_top (
    input  wire                           clk,
    input  wire                           rst,
    input  wire  fetch_pkg::redirect_t    redirect,
    input  wire                           idu_ready,
    input  wire                           arready,
    input  wire                           rvalid,
    input  wire  axi_pkg::r_beat_t        r,
    output wire                           ifu_valid,
    output wire  fetch_pkg::fetch_bundle_t bundle,
    output wire                           access_fault,
    output wire                           arvalid,
    output wire  axi_pkg::ar_req_t        ar,
    output wire                           rready
);
    wire                     icache_req;
    wire [31:0]              icache_addr;
    wire                     hit;
    wire [31:0]              inst;
    wire                     mem_req;
    wire [31:0]              mem_addr;
    wire                     mem_ready;
    wire fetch_pkg::refill_t refill;

    ifu i_ifu (
        .clk          (clk),
        .rst          (rst),
        .redirect     (redirect),
        .idu_ready    (idu_ready),
        .hit          (hit),
        .inst         (inst),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .arready      (arready),
        .rvalid       (rvalid),
        .r            (r),
        .ifu_valid    (ifu_valid),
        .bundle       (bundle),
        .access_fault (access_fault),
        .icache_req   (icache_req),
        .icache_addr  (icache_addr),
        .arvalid      (arvalid),
        .ar           (ar),
        .rready       (rready),
        .mem_ready    (mem_ready),
        .refill       (refill)
    );

    icache i_icache (
        .clk         (clk),
        .rst         (rst),
        .icache_req  (icache_req),
        .icache_addr (icache_addr),
        .mem_ready   (mem_ready),
        .refill      (refill),
        .hit         (hit),
        .inst        (inst),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr)
    );

endmodule

`default_nettype wire

// ==== ifu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defines.svh"

module ifu (
    input  wire                            clk,
    input  wire                            rst,
    input  wire  fetch_pkg::redirect_t     redirect,
    input  wire                            idu_ready,
    input  wire                            hit,
    input  wire  [31:0]                    inst,
    input  wire                            mem_req,
    input  wire  [31:0]                    mem_addr,
    input  wire                            arready,
    input  wire                            rvalid,
    input  wire  axi_pkg::r_beat_t         r,
    output logic                           ifu_valid,
    output fetch_pkg::fetch_bundle_t       bundle,
    output logic                           access_fault,
    output logic                           icache_req,
    output logic [31:0]                    icache_addr,
    output logic                           arvalid,
    output axi_pkg::ar_req_t               ar,
    output logic                           rready,
    output logic                           mem_ready,
    output fetch_pkg::refill_t             refill
);
    localparam int LINE_BITS = `FETCH_LINE_BYTES * 8;
    localparam int WORDS     = `FETCH_LINE_BYTES / 4;
    localparam int CNT_W     = $clog2(WORDS);

    fetch_pkg::fetch_state_e state;
    fetch_pkg::fetch_state_e next_state;

    logic [31:0]          pc;
    logic [31:0]          dnpc;
    logic [31:0]          fetch_pc;
    logic [CNT_W-1:0]     beat_cnt;
    logic [LINE_BITS-1:0] fill_data;
    logic                 fill_fault;

    logic                 in_sdram;
    logic                 issue;
    logic                 deliver_hit;
    logic                 start_miss;
    logic                 ar_fire;
    logic                 r_fire;
    logic                 r_err;
    logic                 line_done;
    logic                 next_single;

    assign dnpc = redirect.valid ? redirect.target : pc + 32'd4;

    // the pc register only moves at the end of ifu_valid, so a fetch
    // issued in that same cycle must already use the next pc.
    assign fetch_pc = ifu_valid ? dnpc : pc;

    assign in_sdram = (mem_addr >= `SDRAM_BASE) && (mem_addr <= `SDRAM_END);

    assign issue       = (state == fetch_pkg::IDLE) && idu_ready;
    assign deliver_hit = (state == fetch_pkg::CHECK) && hit;
    assign start_miss  = (state == fetch_pkg::CHECK) && !hit && mem_req;
    assign ar_fire     = arvalid && arready;
    assign r_fire      = rvalid && rready;
    assign r_err       = r_fire && (r.resp != axi_pkg::OKAY);
    assign line_done   = r_fire && !r_err &&
                         (in_sdram ? r.last : (beat_cnt == CNT_W'(WORDS - 1)));
    assign next_single = r_fire && !r_err && !line_done && !in_sdram;

    assign refill = '{data: fill_data, fault: fill_fault};

    always_comb begin
        case (state)
            fetch_pkg::IDLE:  next_state = idu_ready ? fetch_pkg::CHECK : fetch_pkg::IDLE;
            fetch_pkg::CHECK: begin
                if (hit) begin
                    next_state = fetch_pkg::IDLE;
                end else if (mem_req) begin
                    next_state = fetch_pkg::BUSY;
                end else begin
                    next_state = fetch_pkg::CHECK; // waiting for the cache verdict.
                end
            end
            fetch_pkg::BUSY:  next_state = mem_ready ? fetch_pkg::READ : fetch_pkg::BUSY;
            fetch_pkg::READ:  next_state = fetch_pkg::IDLE;
            default:          next_state = fetch_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= fetch_pkg::IDLE;
            pc           <= `FETCH_RESET_PC;
            ifu_valid    <= 1'b0;
            access_fault <= 1'b0;
            icache_req   <= 1'b0;
            arvalid      <= 1'b0;
            rready       <= 1'b0;
            mem_ready    <= 1'b0;
            beat_cnt     <= '0;
            fill_fault   <= 1'b0;
        end else begin
            state        <= next_state;
            ifu_valid    <= 1'b0; // pulses.
            access_fault <= 1'b0;
            icache_req   <= 1'b0;
            mem_ready    <= 1'b0;
            if (ifu_valid) begin
                pc <= dnpc;
            end
            if (issue) begin
                icache_req <= 1'b1;
            end
            if (deliver_hit) begin
                ifu_valid <= 1'b1;
            end
            if (start_miss) begin
                arvalid    <= 1'b1;
                beat_cnt   <= '0;
                fill_fault <= 1'b0;
            end
            if (ar_fire) begin
                arvalid <= 1'b0;
                rready  <= 1'b1;
            end
            if (r_err) begin
                fill_fault <= 1'b1; // abandon the rest of the line.
                mem_ready  <= 1'b1;
                rready     <= 1'b0;
            end else if (line_done) begin
                mem_ready <= 1'b1;
                rready    <= 1'b0;
            end else if (r_fire) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (!in_sdram) begin
                    arvalid <= 1'b1; // next single-beat read.
                    rready  <= 1'b0;
                end
            end
            if (state == fetch_pkg::READ) begin
                ifu_valid    <= 1'b1;
                access_fault <= fill_fault;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            icache_addr <= fetch_pc;
        end
        if (start_miss) begin
            ar.addr  <= mem_addr;
            ar.len   <= in_sdram ? 8'(WORDS - 1) : 8'd0;
            ar.size  <= 3'd2;
            ar.burst <= in_sdram ? axi_pkg::INCR : axi_pkg::FIXED;
        end else if (next_single) begin
            ar.addr <= mem_addr + ((32'(beat_cnt) + 32'd1) << 2);
        end
        if (r_fire && !r_err) begin
            fill_data[beat_cnt*32 +: 32] <= r.data;
        end
        if (deliver_hit) begin
            bundle <= '{pc: pc, inst: inst};
        end else if (state == fetch_pkg::READ) begin
            bundle <= '{pc: pc, inst: fill_fault ? 32'd0 : inst};
        end
    end

endmodule

`default_nettype wire

// ==== icache.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defines.svh"

module icache (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      icache_req,
    input  wire  [31:0]              icache_addr,
    input  wire                      mem_ready,
    input  wire  fetch_pkg::refill_t refill,
    output logic                     hit,
    output logic [31:0]              inst,
    output logic                     mem_req,
    output logic [31:0]              mem_addr
);
    localparam int LINE_BITS = `FETCH_LINE_BYTES * 8;
    localparam int WORDS     = `FETCH_LINE_BYTES / 4;
    localparam int OFF_W     = $clog2(`FETCH_LINE_BYTES);
    localparam int IDX_W     = $clog2(`FETCH_LINES);
    localparam int TAG_W     = 32 - OFF_W - IDX_W;
    localparam int SEL_W     = $clog2(WORDS);

    logic [LINE_BITS-1:0]    data_mem [`FETCH_LINES];
    logic [TAG_W-1:0]        tag_mem  [`FETCH_LINES];
    logic [`FETCH_LINES-1:0] valid;

    logic                    req_q;
    logic [31:0]             addr_q;
    logic [IDX_W-1:0]        req_idx;
    logic [TAG_W-1:0]        req_tag;
    logic [SEL_W-1:0]        req_sel;
    logic [IDX_W-1:0]        fill_idx;
    logic [TAG_W-1:0]        fill_tag;
    logic                    fill_en;
    logic                    miss;

    assign req_idx  = addr_q[OFF_W +: IDX_W];
    assign req_tag  = addr_q[31 -: TAG_W];
    assign req_sel  = addr_q[2 +: SEL_W];
    assign fill_idx = mem_addr[OFF_W +: IDX_W];
    assign fill_tag = mem_addr[31 -: TAG_W];

    // a faulting refill leaves the line untouched.
    assign fill_en = mem_req && mem_ready && !refill.fault;

    assign hit  = req_q && valid[req_idx] && (tag_mem[req_idx] == req_tag);
    assign miss = req_q && !hit;
    assign inst = data_mem[req_idx][req_sel*32 +: 32]; // word picked by offset.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_q   <= 1'b0;
            mem_req <= 1'b0;
            valid   <= '0;
        end else begin
            req_q <= icache_req;
            if (miss) begin
                mem_req <= 1'b1;
            end else if (mem_ready) begin
                mem_req <= 1'b0;
            end
            if (fill_en) begin
                valid[fill_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (icache_req) begin
            addr_q <= icache_addr;
        end
        if (miss) begin
            mem_addr <= {addr_q[31:OFF_W], {OFF_W{1'b0}}}; // line aligned.
        end
        if (fill_en) begin
            data_mem[fill_idx] <= refill.data;
            tag_mem[fill_idx]  <= fill_tag;
        end
    end

endmodule

`default_nettype wire

// ==== fetch_pkg.sv ====
`default_nettype none

`include "fetch_defines.svh"

package fetch_pkg;

    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        CHECK = 2'b01,
        BUSY  = 2'b10,
        READ  = 2'b11
    } fetch_state_e;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_bundle_t;

    // one whole line as gathered from the bus.
    typedef struct packed {
        logic [`FETCH_LINE_BYTES*8-1:0] data;
        logic                           fault;
    } refill_t;

endpackage

`default_nettype wire

// ==== axi_pkg.sv ====
`default_nettype none

package axi_pkg;

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01
    } axi_burst_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;   // beats minus one.
        logic [2:0]  size;  // log2 of bytes per beat.
        axi_burst_e  burst;
    } ar_req_t;

    typedef struct packed {
        logic [31:0] data;
        axi_resp_e   resp;
        logic        last;
        logic [3:0]  id;
    } r_beat_t;

endpackage

`default_nettype wire

// ==== fetch_defines.svh ====
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// line geometry, 4 words per line by default.
`define FETCH_LINE_BYTES 16
`define FETCH_LINES      16

`define FETCH_RESET_PC   32'h3000_0000

// bursts are only legal inside this window.
`define SDRAM_BASE       32'hA000_0000
`define SDRAM_END        32'hBFFF_FFFF

`endif
